/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = cnn_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/cnn_ctrl.sv */
`timescale 1ns/1ps

module cnn_ctrl #(
	parameter int X_PE = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               inst_empty,
	input  cnn_pkg::instr_t    instruct,
	output logic               inst_req,
	output cnn_pkg::load_cmd_t cmd,
	output logic               cmd_valid,
	input  logic               cmd_done,
	input  logic               busy,
	output cnn_pkg::shift_t    shift
);
	import cnn_pkg::*;

	ctrl_state_t state;

	// One read per instruction, only from idle
	assign inst_req = (state == st_idle) && !inst_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_idle;
			cmd       <= '0;
			cmd_valid <= 1'b0;
			shift     <= '0;
		end else begin
			cmd_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (inst_req)
						state <= st_fetch;
				end
				st_fetch: begin // instruct is valid this cycle
					shift  <= instruct.shift;
					cmd.op <= instruct.op;
					case (instruct.op)
						op_load_weight: begin
							cmd.count <= 8'(X_PE);  // One kernel per channel
							cmd_valid <= 1'b1;
							state     <= st_load;
						end
						op_load_bias: begin
							cmd.count <= 8'd1;      // All biases in one word
							cmd_valid <= 1'b1;
							state     <= st_load;
						end
						op_conv: begin
							cmd.count <= instruct.count;
							cmd_valid <= 1'b1;
							state     <= st_run;
						end
						default: state <= st_idle;
					endcase
				end
				st_load: begin
					if (cmd_done)
						state <= st_idle;
				end
				st_run: begin
					if (cmd_done)
						state <= st_drain;
				end
				st_drain: begin
					// Last results still leaving the PE pipeline
					if (!busy)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* design/cnn_pkg.sv */
package cnn_pkg;

	//////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////

	localparam int KER_TAPS = 9;               // 3x3 window

	typedef logic signed [7:0]  pix_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [19:0] acc_t;         // Nine 16 bit products plus bias
	typedef logic signed [7:0]  result_t;
	typedef logic [3:0]         shift_t;

	typedef logic [KER_TAPS*8-1:0] kernel_t;   // Tap 0 in the low byte
	typedef logic [KER_TAPS*8-1:0] window_t;
	typedef logic [KER_TAPS*8-1:0] feed_word_t;

	//////////////////////////////////////////////////
	// Instructions and control
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_nop,
		op_load_weight,
		op_load_bias,
		op_conv
	} op_t;

	// Word on the instruction FIFO
	typedef struct packed {
		op_t        op;
		logic [7:0] count;                     // Windows for op_conv
		shift_t     shift;
	} instr_t;

	// Controller to loader
	typedef struct packed {
		op_t        op;
		logic [7:0] count;
	} load_cmd_t;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_load,
		st_run,
		st_drain
	} ctrl_state_t;

endpackage

/* design/cnn_top.sv */
`timescale 1ns/1ps

module cnn_top #(
	parameter int X_PE = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         inst_empty,
	input  cnn_pkg::instr_t              instruct,
	output logic                         inst_req,
	input  logic                         feed_empty,
	output logic                         feed_req,
	input  cnn_pkg::feed_word_t          feed_data,
	output logic                         out_valid,
	input  logic                         out_ready,
	output cnn_pkg::result_t [X_PE-1:0]  out_data
);
	import cnn_pkg::*;

	localparam int IDX_W = (X_PE > 1) ? $clog2(X_PE) : 1;

	load_cmd_t        cmd;
	logic             cmd_valid;
	logic             cmd_done;
	logic             busy;
	shift_t           shift;
	logic             w_en;
	logic             b_en;
	logic [IDX_W-1:0] w_idx;
	feed_word_t       param_data;
	window_t          window;
	logic             win_valid;
	logic             stall;
	kernel_t          kernels [X_PE];
	bias_t            biases [X_PE];

	cnn_ctrl #(.X_PE(X_PE)) i_ctrl (
		.clk        (clk),
		.rst        (rst),
		.inst_empty (inst_empty),
		.instruct   (instruct),
		.inst_req   (inst_req),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.cmd_done   (cmd_done),
		.busy       (busy),
		.shift      (shift)
	);

	feed_loader #(.X_PE(X_PE)) i_loader (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.cmd_done   (cmd_done),
		.feed_empty (feed_empty),
		.feed_req   (feed_req),
		.feed_data  (feed_data),
		.w_en       (w_en),
		.b_en       (b_en),
		.w_idx      (w_idx),
		.data       (param_data),
		.window     (window),
		.win_valid  (win_valid),
		.stall      (stall)
	);

	param_buffer #(.X_PE(X_PE)) i_params (
		.clk     (clk),
		.rst     (rst),
		.w_en    (w_en),
		.b_en    (b_en),
		.w_idx   (w_idx),
		.data    (param_data),
		.kernels (kernels),
		.biases  (biases)
	);

	pe_array #(.X_PE(X_PE)) i_pes (
		.clk       (clk),
		.rst       (rst),
		.window    (window),
		.win_valid (win_valid),
		.kernels   (kernels),
		.biases    (biases),
		.shift     (shift),
		.stall     (stall),
		.busy      (busy),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

/* design/conv_pe.sv */
`timescale 1ns/1ps

module conv_pe (
	input  logic              clk,
	input  logic              rst,
	input  logic              adv,
	input  cnn_pkg::window_t  window,
	input  cnn_pkg::kernel_t  kernel,
	input  cnn_pkg::bias_t    bias,
	input  cnn_pkg::shift_t   shift,
	output cnn_pkg::result_t  result
);
	import cnn_pkg::*;

	typedef logic signed [15:0] prod_t;

	prod_t prod_d [KER_TAPS];
	prod_t prod_q [KER_TAPS];
	acc_t  sum_d;
	acc_t  sum_q;
	acc_t  shifted;

	// Stage 1 inputs, signed 8x8 products
	always_comb begin
		for (int k = 0; k < KER_TAPS; k++)
			prod_d[k] = pix_t'(window[k*8 +: 8]) * weight_t'(kernel[k*8 +: 8]);
	end

	// Stage 2 inputs, adder tree seeded with the bias
	always_comb begin
		sum_d = acc_t'(bias);
		for (int k = 0; k < KER_TAPS; k++)
			sum_d = sum_d + acc_t'(prod_q[k]);
	end

	assign shifted = sum_q >>> shift;  // Arithmetic, keeps the sign

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < KER_TAPS; k++)
				prod_q[k] <= '0;
			sum_q  <= '0;
			result <= '0;
		end else if (adv) begin
			prod_q <= prod_d;
			sum_q  <= sum_d;
			// Stage 3, clamp to signed 8 bits
			if (shifted > acc_t'(127))
				result <= 8'sh7f;
			else if (shifted < acc_t'(-128))
				result <= 8'sh80;
			else
				result <= shifted[7:0];
		end
	end

endmodule

/* design/feed_loader.sv */
`timescale 1ns/1ps

module feed_loader #(
	parameter int X_PE = 4,
	localparam int IDX_W = (X_PE > 1) ? $clog2(X_PE) : 1
) (
	input  logic                clk,
	input  logic                rst,
	input  cnn_pkg::load_cmd_t  cmd,
	input  logic                cmd_valid,
	output logic                cmd_done,
	input  logic                feed_empty,
	output logic                feed_req,
	input  cnn_pkg::feed_word_t feed_data,
	output logic                w_en,
	output logic                b_en,
	output logic [IDX_W-1:0]    w_idx,
	output cnn_pkg::feed_word_t data,
	output cnn_pkg::window_t    window,
	output logic                win_valid,
	input  logic                stall
);
	import cnn_pkg::*;

	op_t        cur_op;
	logic [7:0] to_req;      // Words not yet requested
	logic [7:0] to_use;      // Words not yet consumed
	logic       rd_pend;     // Word returns from the FIFO this cycle
	logic       hold_valid;
	feed_word_t hold_data;
	logic       word_valid;
	feed_word_t word;
	logic       consume;

	// Slot holds either the registered word or the one arriving now
	assign word_valid = hold_valid || rd_pend;
	assign word       = hold_valid ? hold_data : feed_data;
	assign consume    = word_valid && (cur_op != op_conv || !stall);
	assign feed_req   = !feed_empty && (to_req != '0) && (!word_valid || consume);

	assign w_en      = consume && (cur_op == op_load_weight);
	assign b_en      = consume && (cur_op == op_load_bias);
	assign win_valid = consume && (cur_op == op_conv);
	assign data      = word;
	assign window    = word;

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_op     <= op_nop;
			to_req     <= '0;
			to_use     <= '0;
			rd_pend    <= 1'b0;
			hold_valid <= 1'b0;
			w_idx      <= '0;
			cmd_done   <= 1'b0;
		end else begin
			rd_pend  <= feed_req;
			cmd_done <= 1'b0;
			if (cmd_valid) begin
				cur_op   <= cmd.op;
				to_req   <= cmd.count;
				to_use   <= cmd.count;
				w_idx    <= '0;
				cmd_done <= (cmd.count == '0);  // Empty command ends at once
			end else begin
				if (feed_req)
					to_req <= to_req - 8'd1;
				if (consume) begin
					to_use   <= to_use - 8'd1;
					cmd_done <= (to_use == 8'd1);
				end
				if (w_en)
					w_idx <= w_idx + 1'b1;
			end
			if (consume)
				hold_valid <= 1'b0;
			else if (rd_pend)
				hold_valid <= 1'b1;             // Park the word during a stall
		end
	end

	always_ff @(posedge clk) begin
		if (rd_pend && !consume)
			hold_data <= feed_data;
	end

endmodule

/* design/param_buffer.sv */
`timescale 1ns/1ps

module param_buffer #(
	parameter int X_PE = 4,
	localparam int IDX_W = (X_PE > 1) ? $clog2(X_PE) : 1
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                w_en,
	input  logic                b_en,
	input  logic [IDX_W-1:0]    w_idx,
	input  cnn_pkg::feed_word_t data,
	output cnn_pkg::kernel_t    kernels [X_PE],
	output cnn_pkg::bias_t      biases [X_PE]
);
	import cnn_pkg::*;

	//////////////////////////////////////////////////
	// Kernel and bias registers, one set per channel
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < X_PE; i++) begin
				kernels[i] <= '0;
				biases[i]  <= '0;
			end
		end else begin
			if (w_en)
				kernels[w_idx] <= data;       // One kernel per feed word
			if (b_en) begin
				// Channel 0 sits in the low bits of the bias word
				for (int i = 0; i < X_PE; i++)
					biases[i] <= data[i*$bits(bias_t) +: $bits(bias_t)];
			end
		end
	end

endmodule

/* design/pe_array.sv */
`timescale 1ns/1ps

module pe_array #(
	parameter int X_PE = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  cnn_pkg::window_t             window,
	input  logic                         win_valid,
	input  cnn_pkg::kernel_t             kernels [X_PE],
	input  cnn_pkg::bias_t               biases [X_PE],
	input  cnn_pkg::shift_t              shift,
	output logic                         stall,
	output logic                         busy,
	output logic                         out_valid,
	input  logic                         out_ready,
	output cnn_pkg::result_t [X_PE-1:0]  out_data
);

	logic [2:0] vld;   // Products, sum, result
	logic       adv;

	assign out_valid = vld[2];
	assign stall     = out_valid && !out_ready;  // Hold the result on the port
	assign adv       = !stall;
	assign busy      = |vld;

	always_ff @(posedge clk) begin
		if (rst)
			vld <= '0;
		else if (adv)
			vld <= {vld[1:0], win_valid};
	end

	//////////////////////////////////////////////////
	// One PE per output channel, same window for all
	//////////////////////////////////////////////////

	for (genvar i = 0; i < X_PE; i++) begin : g_pe
		conv_pe i_pe (
			.clk    (clk),
			.rst    (rst),
			.adv    (adv),
			.window (window),
			.kernel (kernels[i]),
			.bias   (biases[i]),
			.shift  (shift),
			.result (out_data[i])
		);
	end

endmodule

/* include/cnn_tb_ref.svh */
`ifndef CNN_TB_REF_SVH
`define CNN_TB_REF_SVH

// Golden model of one channel
function automatic cnn_pkg::result_t ref_conv(
	input cnn_pkg::window_t win,
	input cnn_pkg::kernel_t ker,
	input cnn_pkg::bias_t   bias,
	input cnn_pkg::shift_t  sh
);
	int acc;
	acc = bias;
	for (int k = 0; k < cnn_pkg::KER_TAPS; k++)
		acc += $signed(win[k*8 +: 8]) * $signed(ker[k*8 +: 8]);
	acc = acc >>> sh;
	if (acc > 127)
		return 8'sh7f;
	if (acc < -128)
		return 8'sh80;
	return acc[7:0];
endfunction

// Random source for stimulus
logic [31:0] xs_state = 32'd4;

function automatic logic [31:0] xorshift32();
	xs_state = xs_state ^ (xs_state << 13);
	xs_state = xs_state ^ (xs_state >> 17);
	xs_state = xs_state ^ (xs_state << 5);
	return xs_state;
endfunction

`endif

/* tb/cnn_tb.sv */
`timescale 1ns/1ps

module cnn_tb;
	import cnn_pkg::*;

	`include "cnn_tb_ref.svh"

	localparam int X_PE = 4;
	localparam int TIMEOUT_CYCLES = 5000;

	logic clk;
	logic rst;
	logic inst_empty;
	instr_t instruct;
	logic inst_req;
	logic feed_empty;
	logic feed_req;
	feed_word_t feed_data;
	logic out_valid;
	logic out_ready;
	result_t [X_PE-1:0] out_data;

	instr_t instr_q [$];
	feed_word_t feed_q [$];
	logic [X_PE*8-1:0] exp_q [$];
	kernel_t ker_m [X_PE];                  // Testbench copy of the loaded kernels
	bias_t bias_m [X_PE];
	logic inst_rd = 1'b0;
	logic feed_rd = 1'b0;
	logic feed_gap = 1'b0;
	bit bp_mode = 1'b0;
	bit timed_out = 1'b0;
	bit held_valid = 1'b0;
	logic [X_PE*8-1:0] held_data;
	string cur_test = "reset";
	int errs = 0;
	int n_got = 0;
	int err_mark;
	int got_mark;
	int planned;
	int n_pass = 0;
	int n_fail = 0;

	cnn_top #(.X_PE(X_PE)) i_dut (
		.clk        (clk),
		.rst        (rst),
		.inst_empty (inst_empty),
		.instruct   (instruct),
		.inst_req   (inst_req),
		.feed_empty (feed_empty),
		.feed_req   (feed_req),
		.feed_data  (feed_data),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// FIFO models with one cycle read latency
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		logic [31:0] r;
		r = xorshift32();
		inst_rd  <= inst_req;
		feed_rd  <= feed_req;
		feed_gap <= bp_mode && r[1];  // Random gaps in the feed
	end

	always @(negedge clk) begin
		if (inst_rd) begin
			assert (instr_q.size() != 0) else begin
				$display("Instruction FIFO was read while empty in %s", cur_test);
				errs++;
			end
			if (instr_q.size() != 0)
				instruct = instr_q.pop_front();
		end
		if (feed_rd) begin
			assert (feed_q.size() != 0) else begin
				$display("Feed FIFO was read while empty in %s", cur_test);
				errs++;
			end
			if (feed_q.size() != 0)
				feed_data = feed_q.pop_front();
		end
		inst_empty = (instr_q.size() == 0);
		feed_empty = (feed_q.size() == 0) || feed_gap;
	end

	//////////////////////////////////////////////////
	// Next out_ready, then result compare
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		logic [31:0] r;
		logic [X_PE*8-1:0] exp_v;
		r = xorshift32();
		out_ready = !bp_mode || r[0];  // Holds through the next rising edge
		if (!rst) begin
			if (held_valid) begin
				assert (out_valid && out_data === held_data) else begin
					$display("Result changed while out_ready was low in %s", cur_test);
					errs++;
				end
			end
			held_valid = out_valid && !out_ready;
			held_data  = out_data;
			if (out_valid && out_ready) begin  // Transfers on the next rising edge
				n_got++;
				assert (exp_q.size() != 0) else begin
					$display("A result came out with none expected in %s", cur_test);
					errs++;
				end
				if (exp_q.size() != 0) begin
					exp_v = exp_q.pop_front();
					assert (out_data === exp_v) else begin
						$display("Error: %s expected %h actual %h", cur_test, exp_v, out_data);
						errs++;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic feed_word_t random_word();
		logic [95:0] t;
		t = {xorshift32(), xorshift32(), xorshift32()};
		return t[71:0];
	endfunction

	task automatic queue_instr(input op_t op, input int count, input shift_t sh);
		instr_t ins;
		ins.op    = op;
		ins.count = 8'(count);
		ins.shift = sh;
		instr_q.push_back(ins);
	endtask

	task automatic load_weights(input bit extreme);
		queue_instr(op_load_weight, 0, 4'd0);
		for (int i = 0; i < X_PE; i++) begin
			if (extreme)
				ker_m[i] = (i % 2 == 0) ? {KER_TAPS{8'h7f}} : {KER_TAPS{8'h80}};
			else
				ker_m[i] = random_word();
			feed_q.push_back(ker_m[i]);
		end
	endtask

	task automatic load_biases();
		feed_word_t w;
		logic [31:0] r;
		queue_instr(op_load_bias, 0, 4'd0);
		w = '0;
		for (int i = 0; i < X_PE; i++) begin
			r = xorshift32();
			bias_m[i] = bias_t'($signed(r[11:0]));  // Keep biases near the product range
			w[i*16 +: 16] = bias_m[i];
		end
		feed_q.push_back(w);
	endtask

	task automatic conv_windows(input int count, input shift_t sh, input bit extreme);
		window_t w;
		logic [X_PE*8-1:0] e;
		queue_instr(op_conv, count, sh);
		for (int n = 0; n < count; n++) begin
			if (extreme && n % 3 == 0)
				w = {KER_TAPS{8'h7f}};
			else if (extreme && n % 3 == 1)
				w = {KER_TAPS{8'h80}};
			else
				w = random_word();
			feed_q.push_back(w);
			for (int i = 0; i < X_PE; i++)
				e[i*8 +: 8] = ref_conv(w, ker_m[i], bias_m[i], sh);
			exp_q.push_back(e);
		end
		planned += count;
	endtask

	task automatic wait_idle(input string what);
		int cycles;
		cycles = 0;
		while (!timed_out && !(instr_q.size() == 0 && feed_q.size() == 0 &&
				exp_q.size() == 0 && !inst_rd && !out_valid &&
				i_dut.i_ctrl.state == st_idle)) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("Timeout: %s did not finish within %0d cycles", what, TIMEOUT_CYCLES);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = errs;
		got_mark = n_got;
		planned  = 0;
	endtask

	task automatic report_test();
		wait_idle(cur_test);
		assert (n_got - got_mark == planned) else begin
			$display("Test %s got %0d results but issued %0d windows", cur_test,
				n_got - got_mark, planned);
			errs++;
		end
		if (errs == err_mark && !timed_out) begin
			n_pass++;
			$display("%-12s ok    %0d results", cur_test, n_got - got_mark);
		end else begin
			n_fail++;
			$display("%-12s FAIL  %0d errors", cur_test, errs - err_mark);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		inst_empty = 1'b1;
		instruct   = '0;
		feed_empty = 1'b1;
		feed_data  = '0;
		out_ready  = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		#1;

		start_test("reset_nop");
		assert (!inst_req && !feed_req && !out_valid) else begin
			$display("inst_req, feed_req or out_valid is high after reset");
			errs++;
		end
		queue_instr(op_nop, 0, 4'd0);
		report_test();

		start_test("basic_conv");
		load_weights(1'b0);
		load_biases();
		conv_windows(20, 4'd4, 1'b0);
		report_test();

		start_test("backpressure");
		bp_mode = 1'b1;
		conv_windows(20, 4'd4, 1'b0);
		report_test();
		bp_mode = 1'b0;

		start_test("bias_reload");
		load_biases();                      // Weights stay as loaded before
		conv_windows(20, 4'd4, 1'b0);
		report_test();

		start_test("saturation");
		load_weights(1'b1);
		conv_windows(12, 4'd0, 1'b1);
		report_test();

		start_test("queued");
		load_weights(1'b0);
		conv_windows(5, 4'd3, 1'b0);
		load_biases();
		conv_windows(7, 4'd5, 1'b0);
		conv_windows(3, 4'd2, 1'b0);
		queue_instr(op_nop, 0, 4'd0);
		conv_windows(4, 4'd6, 1'b0);
		report_test();

		$display("Tests: %0d ok, %0d failing, %0d errors, %0d results checked",
			n_pass, n_fail, errs, n_got);
		if (errs == 0 && n_fail == 0 && !timed_out)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
design/cnn_pkg.sv
design/conv_pe.sv
design/pe_array.sv
design/param_buffer.sv
design/feed_loader.sv
design/cnn_ctrl.sv
design/cnn_top.sv
tb/cnn_tb.sv
